// File: src/crc_ahb_pkg.sv
`default_nettype none

package crc_ahb_pkg;

	////////////////////
	// Register map
	////////////////////

	// Register index taken from HADDR[4:2]
	typedef enum logic [2:0] {
		REG_DR   = 3'd0,
		REG_IDR  = 3'd1,
		REG_CR   = 3'd2,
		REG_INIT = 3'd4,
		REG_POL  = 3'd5
	} crc_reg_addr_t;

	// AHB transfer type
	typedef enum logic [1:0] {
		IDLE   = 2'b00,
		BUSY   = 2'b01,
		NONSEQ = 2'b10,
		SEQ    = 2'b11
	} htrans_t;

	// Width of one data item, low bits of HSIZE
	typedef enum logic [1:0] {
		SIZE_BYTE = 2'd0,
		SIZE_HALF = 2'd1,
		SIZE_WORD = 2'd2
	} bus_size_t;

	////////////////////
	// Control encodings
	////////////////////

	// CRC width
	typedef enum logic [1:0] {
		POLY_32 = 2'd0,
		POLY_16 = 2'd1,
		POLY_8  = 2'd2,
		POLY_7  = 2'd3
	} poly_size_t;

	// Input bit reversal granularity
	typedef enum logic [1:0] {
		REV_NONE = 2'd0,
		REV_BYTE = 2'd1,
		REV_HALF = 2'd2,
		REV_WORD = 2'd3
	} rev_in_t;

	// Field order matches CR[7:3] bit for bit
	typedef struct packed {
		logic       rev_out;
		rev_in_t    rev_in;
		poly_size_t poly_size;
	} crc_cfg_t;

	// One buffered data item, data sits above the size field
	typedef struct packed {
		logic [31:0] data;
		bus_size_t   size;
	} crc_chunk_t;

	// Reset values
	localparam crc_cfg_t    CR_RESET   = '0;
	localparam logic [31:0] INIT_RESET = 32'hFFFF_FFFF;
	localparam logic [31:0] POLY_RESET = 32'h04C1_1DB7;

endpackage

`default_nettype wire

// File: src/crc_host_interface.sv
`timescale 1ns/100ps
`default_nettype none

module crc_host_interface
(
	input  wire                    HCLK,
	input  wire                    HRESETn,
	input  wire                    HSElx,
	input  wire [31:0]             HADDR,
	input  crc_ahb_pkg::htrans_t   HTRANS,
	input  wire                    HWRITE,
	input  wire [2:0]              HSIZE,
	input  wire                    HREADY,
	input  wire [31:0]             HWDATA,
	output logic [31:0]            HRDATA,
	output logic                   HREADYOUT,
	output logic                   HRESP,
	input  wire [31:0]             crc_value,
	input  wire [31:0]             init_value,
	input  wire [31:0]             poly_value,
	input  wire [7:0]              idr_value,
	input  wire                    full,
	input  wire                    busy,
	input  wire                    reset_pending,
	output crc_ahb_pkg::crc_cfg_t  cfg,
	output logic [31:0]            wr_data,
	output logic                   dr_we,
	output crc_ahb_pkg::bus_size_t dr_size,
	output logic                   init_we,
	output logic                   poly_we,
	output logic                   idr_we,
	output logic                   reset_chain
);

	// Registered address phase
	logic                       hsel_q;
	logic                       hwrite_q;
	crc_ahb_pkg::htrans_t       htrans_q;
	crc_ahb_pkg::crc_reg_addr_t addr_q;
	crc_ahb_pkg::bus_size_t     size_q;

	// Control register
	crc_ahb_pkg::crc_cfg_t cfg_q;

	logic sample;
	logic write_en;
	logic read_en;
	logic cr_we;

	////////////////////
	// Address phase
	////////////////////

	// A transfer is taken only when the bus is ready on both sides
	assign sample = HREADY && HREADYOUT;

	always_ff @(posedge HCLK)
	begin
		if (!HRESETn)
		begin
			hsel_q   <= 1'b0;
			hwrite_q <= 1'b0;
			htrans_q <= crc_ahb_pkg::IDLE;
		end
		else if (sample)
		begin
			hsel_q   <= HSElx;
			hwrite_q <= HWRITE;
			htrans_q <= HTRANS;
		end
	end

	// Address and size are payload, only valid with hsel_q
	always_ff @(posedge HCLK)
	begin
		if (sample)
		begin
			addr_q <= crc_ahb_pkg::crc_reg_addr_t'(HADDR[4:2]);
			size_q <= crc_ahb_pkg::bus_size_t'(HSIZE[1:0]);
		end
	end

	// SEQ, BUSY and IDLE are ignored
	assign write_en = hsel_q && (htrans_q == crc_ahb_pkg::NONSEQ) && hwrite_q;
	assign read_en  = hsel_q && (htrans_q == crc_ahb_pkg::NONSEQ) && !hwrite_q;

	////////////////////
	// Write strobes
	////////////////////

	// Held back while the target cannot take the data
	assign dr_we   = write_en && (addr_q == crc_ahb_pkg::REG_DR) && !full;
	assign init_we = write_en && (addr_q == crc_ahb_pkg::REG_INIT) && !reset_pending;
	assign poly_we = write_en && (addr_q == crc_ahb_pkg::REG_POL);
	assign idr_we  = write_en && (addr_q == crc_ahb_pkg::REG_IDR);
	assign cr_we   = write_en && (addr_q == crc_ahb_pkg::REG_CR);

	// CR bit 0 restarts the CRC from INIT
	assign reset_chain = cr_we && HWDATA[0];

	// Write data is used in its own data phase
	assign wr_data = HWDATA;
	assign dr_size = size_q;

	always_ff @(posedge HCLK)
	begin
		if (!HRESETn)
			cfg_q <= crc_ahb_pkg::CR_RESET;
		else if (cr_we)
			cfg_q <= crc_ahb_pkg::crc_cfg_t'(HWDATA[7:3]);
	end

	assign cfg = cfg_q;

	////////////////////
	// Read side
	////////////////////

	always_comb
	begin
		case (addr_q)
			crc_ahb_pkg::REG_DR:   HRDATA = crc_value;
			crc_ahb_pkg::REG_IDR:  HRDATA = {24'h0, idr_value};
			crc_ahb_pkg::REG_CR:   HRDATA = {24'h0, cfg_q, 3'b000};
			crc_ahb_pkg::REG_INIT: HRDATA = init_value;
			crc_ahb_pkg::REG_POL:  HRDATA = poly_value;
			default:               HRDATA = 32'h0;
		endcase
	end

	// Wait states: DR write on full buffer, DR read until all data folded,
	// INIT write while a CRC restart is still waiting
	assign HREADYOUT = !((write_en && (addr_q == crc_ahb_pkg::REG_DR) && full) ||
		(read_en && (addr_q == crc_ahb_pkg::REG_DR) && (full || busy)) ||
		(write_en && (addr_q == crc_ahb_pkg::REG_INIT) && reset_pending));

	// No error responses
	assign HRESP = 1'b0;

	// Anything but a selected NONSEQ leaves no wait state behind
	assert property (@(posedge HCLK) disable iff (!HRESETn)
		sample && !(HSElx && (HTRANS == crc_ahb_pkg::NONSEQ)) |=> HREADYOUT);

	// Strobes fire only in the closing cycle of a data phase, so each lasts one cycle
	assert property (@(posedge HCLK) disable iff (!HRESETn)
		(dr_we || init_we || poly_we || idr_we || cr_we) |-> HREADY);

	assert property (@(posedge HCLK) disable iff (!HRESETn)
		$onehot0({dr_we, init_we, poly_we, idr_we, cr_we}));

endmodule

`default_nettype wire

// File: src/crc_input_buffer.sv
`timescale 1ns/100ps
`default_nettype none

module crc_input_buffer
(
	input  wire                     HCLK,
	input  wire                     HRESETn,
	input  wire                     dr_we,
	input  crc_ahb_pkg::bus_size_t  dr_size,
	input  wire [31:0]              wr_data,
	input  wire                     ack,
	output logic                    full,
	output logic                    req,
	output crc_ahb_pkg::crc_chunk_t chunk
);

	// Handshake phase flags
	logic req_q;
	logic drop_q;

	crc_ahb_pkg::crc_chunk_t chunk_q;

	////////////////////
	// Handshake
	////////////////////

	always_ff @(posedge HCLK)
	begin
		if (!HRESETn)
		begin
			req_q  <= 1'b0;
			drop_q <= 1'b0;
		end
		else if (dr_we)
		begin
			// New item, engine is idle with ack low
			req_q  <= 1'b1;
			drop_q <= 1'b0;
		end
		else if (req_q && ack)
		begin
			// Engine is done, release the request
			req_q  <= 1'b0;
			drop_q <= 1'b1;
		end
		else if (drop_q && !ack)
			drop_q <= 1'b0;
	end

	// Item register, loaded only when empty
	always_ff @(posedge HCLK)
	begin
		if (dr_we)
		begin
			chunk_q.data <= wr_data;
			chunk_q.size <= dr_size;
		end
	end

	// Empty again as soon as ack has fallen
	assign full  = req_q || (drop_q && ack);
	assign req   = req_q;
	assign chunk = chunk_q;

	// Engine reads the item across several cycles
	assert property (@(posedge HCLK) disable iff (!HRESETn)
		req |=> $stable(chunk));

	assert property (@(posedge HCLK) disable iff (!HRESETn)
		dr_we |-> !full);

endmodule

`default_nettype wire

// File: src/crc_compute.sv
`timescale 1ns/100ps
`default_nettype none

module crc_compute
(
	input  wire                     HCLK,
	input  wire                     HRESETn,
	input  crc_ahb_pkg::crc_cfg_t   cfg,
	input  wire [31:0]              wr_data,
	input  wire                     init_we,
	input  wire                     poly_we,
	input  wire                     idr_we,
	input  wire                     reset_chain,
	input  wire                     req,
	input  crc_ahb_pkg::crc_chunk_t chunk,
	output logic                    ack,
	output logic                    busy,
	output logic                    reset_pending,
	output logic [31:0]             crc_value,
	output logic [31:0]             init_value,
	output logic [31:0]             poly_value,
	output logic [7:0]              idr_value
);

	typedef enum logic [1:0] {ST_IDLE, ST_FOLD, ST_ACK} state_t;

	state_t      state_q;
	logic        ack_q;
	logic        pending_q;
	logic [31:0] init_q;
	logic [31:0] poly_q;
	logic [7:0]  idr_q;
	logic [31:0] crc_q;
	// Bytes still to fold, most significant at the top
	logic [31:0] shreg;
	logic [1:0]  cnt;
	logic [4:0]  shift;
	logic [31:0] aligned;
	logic [1:0]  last;
	logic        reset_ok;

	// Bit reversal within each byte
	function automatic logic [31:0] rev_bytes(input logic [31:0] d);
		logic [31:0] r;
		for (int i = 0; i < 32; i++)
			r[i] = d[(i / 8) * 8 + 7 - (i % 8)];
		return r;
	endfunction

	// Bit reversal within each halfword
	function automatic logic [31:0] rev_halves(input logic [31:0] d);
		logic [31:0] r;
		for (int i = 0; i < 32; i++)
			r[i] = d[(i / 16) * 16 + 15 - (i % 16)];
		return r;
	endfunction

	function automatic logic [31:0] rev_word(input logic [31:0] d);
		logic [31:0] r;
		for (int i = 0; i < 32; i++)
			r[i] = d[31 - i];
		return r;
	endfunction

	// One byte, MSB first, with CRC and polynomial moved to the top of the word
	function automatic logic [31:0] fold_byte(input logic [31:0] crc, input logic [31:0] poly,
		input logic [7:0] din, input logic [4:0] sh);
		logic [31:0] a;
		logic [31:0] p;
		a = (crc << sh) ^ {din, 24'h0};
		p = poly << sh;
		for (int k = 0; k < 8; k++)
			a = a[31] ? ((a << 1) ^ p) : (a << 1);
		return a >> sh;
	endfunction

	////////////////////
	// Input preparation
	////////////////////

	// Distance from the CRC width up to bit 31
	always_comb
	begin
		case (cfg.poly_size)
			crc_ahb_pkg::POLY_16: shift = 5'd16;
			crc_ahb_pkg::POLY_8:  shift = 5'd24;
			crc_ahb_pkg::POLY_7:  shift = 5'd25;
			default:              shift = 5'd0;
		endcase
	end

	// Reversal never reaches past the item width
	always_comb
	begin
		case (chunk.size)
			crc_ahb_pkg::SIZE_BYTE:
			begin
				last    = 2'd0;
				aligned = ((cfg.rev_in == crc_ahb_pkg::REV_NONE) ? chunk.data :
					rev_bytes(chunk.data)) << 24;
			end
			crc_ahb_pkg::SIZE_HALF:
			begin
				last = 2'd1;
				case (cfg.rev_in)
					crc_ahb_pkg::REV_NONE: aligned = chunk.data << 16;
					crc_ahb_pkg::REV_BYTE: aligned = rev_bytes(chunk.data) << 16;
					default:               aligned = rev_halves(chunk.data) << 16;
				endcase
			end
			default:
			begin
				// HSIZE above word is folded as a word
				last = 2'd3;
				case (cfg.rev_in)
					crc_ahb_pkg::REV_NONE: aligned = chunk.data;
					crc_ahb_pkg::REV_BYTE: aligned = rev_bytes(chunk.data);
					crc_ahb_pkg::REV_HALF: aligned = rev_halves(chunk.data);
					default:               aligned = rev_word(chunk.data);
				endcase
			end
		endcase
	end

	////////////////////
	// Engine
	////////////////////

	// Restart waits for the item in flight, also one still waiting in IDLE
	assign reset_ok = !req && (state_q != ST_FOLD);

	always_ff @(posedge HCLK)
	begin
		if (!HRESETn)
		begin
			state_q   <= ST_IDLE;
			ack_q     <= 1'b0;
			pending_q <= 1'b0;
			crc_q     <= crc_ahb_pkg::INIT_RESET;
		end
		else
		begin
			case (state_q)
				ST_IDLE:
					if (req && !ack_q)
					begin
						shreg   <= aligned;
						cnt     <= last;
						state_q <= ST_FOLD;
					end
				ST_FOLD:
				begin
					crc_q <= fold_byte(crc_q, poly_q, shreg[31:24], shift);
					shreg <= shreg << 8;
					cnt   <= cnt - 2'd1;
					if (cnt == 2'd0)
					begin
						ack_q   <= 1'b1;
						state_q <= ST_ACK;
					end
				end
				default:
					if (!req)
					begin
						ack_q   <= 1'b0;
						state_q <= ST_IDLE;
					end
			endcase
			// Never in FOLD here, so no clash with the fold update
			if ((reset_chain || pending_q) && reset_ok)
			begin
				crc_q     <= init_q;
				pending_q <= 1'b0;
			end
			else if (reset_chain)
				pending_q <= 1'b1;
		end
	end

	// Programmable registers
	always_ff @(posedge HCLK)
	begin
		if (!HRESETn)
		begin
			init_q <= crc_ahb_pkg::INIT_RESET;
			poly_q <= crc_ahb_pkg::POLY_RESET;
			idr_q  <= 8'h00;
		end
		else
		begin
			if (init_we)
				init_q <= wr_data;
			if (poly_we)
				poly_q <= wr_data;
			if (idr_we)
				idr_q <= wr_data[7:0];
		end
	end

	// Output reversal mirrors only the low CRC-width bits
	assign crc_value = cfg.rev_out ? (rev_word(crc_q) >> shift) :
		(crc_q & (32'hFFFF_FFFF >> shift));

	assign ack           = ack_q;
	assign busy          = (state_q != ST_IDLE);
	assign reset_pending = pending_q;
	assign init_value    = init_q;
	assign poly_value    = poly_q;
	assign idr_value     = idr_q;

	assert property (@(posedge HCLK) disable iff (!HRESETn)
		$rose(ack) |-> req);

endmodule

`default_nettype wire

// File: src/crc_ahb_top.sv
`timescale 1ns/100ps
`default_nettype none

module crc_ahb_top
(
	input  wire                  HCLK,
	input  wire                  HRESETn,
	input  wire                  HSElx,
	input  wire [31:0]           HADDR,
	input  crc_ahb_pkg::htrans_t HTRANS,
	input  wire                  HWRITE,
	input  wire [2:0]            HSIZE,
	input  wire                  HREADY,
	input  wire [31:0]           HWDATA,
	output wire [31:0]           HRDATA,
	output wire                  HREADYOUT,
	output wire                  HRESP
);

	// Host side to engine and buffer
	wire crc_ahb_pkg::crc_cfg_t   cfg;
	wire [31:0]                   wr_data;
	wire                          dr_we;
	wire crc_ahb_pkg::bus_size_t  dr_size;
	wire                          init_we;
	wire                          poly_we;
	wire                          idr_we;
	wire                          reset_chain;

	// Status and read data back to the host side
	wire [31:0]                   crc_value;
	wire [31:0]                   init_value;
	wire [31:0]                   poly_value;
	wire [7:0]                    idr_value;
	wire                          full;
	wire                          busy;
	wire                          reset_pending;

	// Four-phase link between buffer and engine
	wire                          req;
	wire                          ack;
	wire crc_ahb_pkg::crc_chunk_t chunk;

	crc_host_interface i_host (
		.HCLK, .HRESETn, .HSElx, .HADDR, .HTRANS, .HWRITE, .HSIZE, .HREADY, .HWDATA,
		.HRDATA, .HREADYOUT, .HRESP,
		.crc_value, .init_value, .poly_value, .idr_value, .full, .busy, .reset_pending,
		.cfg, .wr_data, .dr_we, .dr_size, .init_we, .poly_we, .idr_we, .reset_chain
	);

	crc_input_buffer i_buffer (
		.HCLK, .HRESETn, .dr_we, .dr_size, .wr_data, .ack, .full, .req, .chunk
	);

	crc_compute i_compute (
		.HCLK, .HRESETn, .cfg, .wr_data, .init_we, .poly_we, .idr_we, .reset_chain,
		.req, .chunk, .ack, .busy, .reset_pending,
		.crc_value, .init_value, .poly_value, .idr_value
	);

endmodule

`default_nettype wire

// File: tests/tb_clock_gen.sv
`timescale 1ns/100ps
`default_nettype none

module tb_clock_gen
(
	output logic HCLK,
	output logic HRESETn
);

	localparam int RESET_CYCLES = 10;

	// 4 ns period
	initial
	begin
		HCLK = 1'b0;
		forever
			#2 HCLK = ~HCLK;
	end

	// Synchronous reset, released just after a rising edge
	initial
	begin
		HRESETn = 1'b0;
		repeat (RESET_CYCLES)
			@(posedge HCLK);
		#1;
		HRESETn = 1'b1;
	end

endmodule

`default_nettype wire

// File: tests/crc_ahb_tb.sv
`timescale 1ns/100ps
`default_nettype none

module crc_ahb_tb;

	localparam int MAX_LINES       = 80;
	localparam int LINE_FIELDS     = 5;
	localparam int CYCLES_PER_LINE = 40;

	// CR bits outside the config fields, bit 0 included
	localparam logic [31:0] CR_SPARE_MASK = 32'hFFFF_FF07;

	wire HCLK;
	wire HRESETn;

	// Master side of the bus
	logic                 HSElx;
	logic [31:0]          HADDR;
	crc_ahb_pkg::htrans_t HTRANS;
	logic                 HWRITE;
	logic [2:0]           HSIZE;
	logic [31:0]          HWDATA;
	wire                  HREADY;
	wire [31:0]           HRDATA;
	wire                  HREADYOUT;
	wire                  HRESP;

	// Stimulus image, five words per line
	logic [31:0] stim [0:MAX_LINES*LINE_FIELDS-1];
	int n_lines = 0;
	int cycle_limit = 0;
	int cycle_count = 0;

	// Result counters
	int checks = 0;
	int errors = 0;
	int test_errors = 0;
	int tests_passed = 0;
	int tests_failed = 0;

	tb_clock_gen i_clock (.HCLK, .HRESETn);

	// Only slave on the bus
	assign HREADY = HREADYOUT;

	crc_ahb_top i_dut (
		.HCLK, .HRESETn, .HSElx, .HADDR, .HTRANS, .HWRITE, .HSIZE, .HREADY, .HWDATA,
		.HRDATA, .HREADYOUT, .HRESP
	);

	////////////////////
	// Compare tasks
	////////////////////

	function automatic string reg_name(input logic [31:0] addr);
		case (addr[4:2])
			3'd0:    return "DR";
			3'd1:    return "IDR";
			3'd2:    return "CR";
			3'd4:    return "INIT";
			3'd5:    return "POL";
			default: return "unmapped";
		endcase
	endfunction

	task automatic check_data(input string what, input logic [31:0] got,
		input logic [31:0] exp);
		checks++;
		if (got !== exp)
		begin
			errors++;
			test_errors++;
			$display("ERR @%0t ns: %s read 0x%08h, expected 0x%08h", $time, what, got, exp);
		end
	endtask

	task automatic check_cfg(input crc_ahb_pkg::crc_cfg_t got,
		input crc_ahb_pkg::crc_cfg_t exp);
		checks++;
		if (got !== exp)
		begin
			errors++;
			test_errors++;
			$display("ERR @%0t ns: CR poly_size %0d rev_in %0d rev_out %0b, expected %0d %0d %0b",
				$time, got.poly_size, got.rev_in, got.rev_out,
				exp.poly_size, exp.rev_in, exp.rev_out);
		end
	endtask

	// The unit always answers OKAY
	task automatic check_resp(input logic got);
		checks++;
		if (got !== 1'b0)
		begin
			errors++;
			test_errors++;
			$display("ERR @%0t ns: HRESP is %b, expected OKAY", $time, got);
		end
	endtask

	// CR fields as a config struct, the rest of CR as a plain word
	task automatic check_read(input logic [31:0] addr, input logic [31:0] got,
		input logic [31:0] exp);
		if (addr[4:2] == crc_ahb_pkg::REG_CR)
		begin
			check_cfg(crc_ahb_pkg::crc_cfg_t'(got[7:3]), crc_ahb_pkg::crc_cfg_t'(exp[7:3]));
			check_data("CR spare bits", got & CR_SPARE_MASK, exp & CR_SPARE_MASK);
		end
		else
			check_data(reg_name(addr), got, exp);
	endtask

	task automatic finish_test(input int test);
		if (test_errors == 0)
		begin
			tests_passed++;
			$display("test %0d PASS", test);
		end
		else
		begin
			tests_failed++;
			$display("ERR @%0t ns: test %0d ended with %0d mismatches", $time, test, test_errors);
		end
		test_errors = 0;
	endtask

	////////////////////
	// Bus master
	////////////////////

	task automatic drive_addr(input logic sel, input logic wr, input logic [2:0] size,
		input logic [31:0] addr);
		HSElx  = sel;
		HTRANS = sel ? crc_ahb_pkg::NONSEQ : crc_ahb_pkg::IDLE;
		HWRITE = wr;
		HSIZE  = size;
		HADDR  = addr;
	endtask

	// Ends one bus cycle with HREADYOUT high, inputs held through wait states
	task automatic wait_ready(output logic [31:0] rdata);
		@(negedge HCLK);
		while (!HREADYOUT)
			@(negedge HCLK);
		rdata = HRDATA;
		check_resp(HRESP);
		@(posedge HCLK);
		#1;
	endtask

	initial
	begin
		logic [31:0] rdata;
		logic        prev_valid;
		logic        prev_write;
		logic [31:0] prev_addr;
		logic [31:0] prev_data;
		int          prev_test;
		int          base;

		HSElx      = 1'b0;
		HADDR      = 32'h0;
		HTRANS     = crc_ahb_pkg::IDLE;
		HWRITE     = 1'b0;
		HSIZE      = 3'd0;
		HWDATA     = 32'h0;
		prev_valid = 1'b0;
		prev_write = 1'b0;
		prev_addr  = 32'h0;
		prev_data  = 32'h0;
		prev_test  = 0;

		// Lines up to the zero test number
		$readmemh("tests/crc_stimulus.txt", stim);
		while (n_lines < MAX_LINES && stim[n_lines*LINE_FIELDS] !== 32'h0 &&
			!$isunknown(stim[n_lines*LINE_FIELDS]))
			n_lines++;
		cycle_limit = (n_lines + 1) * CYCLES_PER_LINE;
		if (n_lines == 0)
			$display("Stimulus file tests/crc_stimulus.txt holds no test lines");

		wait (HRESETn === 1'b1);
		@(posedge HCLK);
		#1;

		for (int i = 0; i < n_lines; i++)
		begin
			base = i * LINE_FIELDS;
			// Address phase of this line over the data phase of the line before
			drive_addr(1'b1, stim[base+1][0], stim[base+2][2:0], stim[base+3]);
			HWDATA = prev_write ? prev_data : 32'h0;
			wait_ready(rdata);
			if (prev_valid)
			begin
				if (!prev_write)
					check_read(prev_addr, rdata, prev_data);
				if (prev_test != int'(stim[base]))
					finish_test(prev_test);
			end
			prev_valid = 1'b1;
			prev_write = stim[base+1][0];
			prev_addr  = stim[base+3];
			prev_data  = stim[base+4];
			prev_test  = int'(stim[base]);
		end

		// Last data phase behind an idle address phase
		drive_addr(1'b0, 1'b0, 3'd0, 32'h0);
		HWDATA = prev_write ? prev_data : 32'h0;
		wait_ready(rdata);
		if (prev_valid)
		begin
			if (!prev_write)
				check_read(prev_addr, rdata, prev_data);
			finish_test(prev_test);
		end

		$display("tests passed %0d, failed %0d, checks %0d, errors %0d",
			tests_passed, tests_failed, checks, errors);
		if (errors == 0 && tests_failed == 0 && n_lines > 0)
			$display(">>> PASS");
		else
			$display(">>> FAIL");
		$finish;
	end

	// Watchdog, limit scales with the number of stimulus lines
	initial
	begin
		wait (cycle_limit > 0);
		while (cycle_count < cycle_limit)
		begin
			@(posedge HCLK);
			cycle_count++;
		end
		$display("Timeout: the run did not finish within %0d clock cycles", cycle_count);
		$display(">>> FAIL");
		$finish;
	end

endmodule

`default_nettype wire

// File: crc_ahb_top.f
src/crc_ahb_pkg.sv
src/crc_host_interface.sv
src/crc_input_buffer.sv
src/crc_compute.sv
src/crc_ahb_top.sv
tests/tb_clock_gen.sv
tests/crc_ahb_tb.sv

// File: tests/crc_stimulus.txt
// Columns: test, op (1 write, 0 read), HSIZE, byte address, write data or expected read
// Addresses: 00 DR, 04 IDR, 08 CR, 10 INIT, 14 POL; a line with test 0 ends the list
1 0 2 10 FFFFFFFF
1 0 2 14 04C11DB7
1 0 2 08 00000000
1 0 2 00 FFFFFFFF
// CRC-32/MPEG-2
2 1 2 08 00000001
2 1 2 00 12345678
2 0 2 00 DF8A8A2B
2 1 2 08 00000001
2 1 2 00 31323334
2 1 2 00 35363738
2 1 0 00 00000039
2 0 2 00 0376E6E7
// CRC-16 poly 1021 init FFFF, then CRC-8 poly 07 and CRC-7 poly 09 with init 0
3 1 2 14 00001021
3 1 2 08 00000009
3 1 1 00 00003132
3 1 2 00 33343536
3 1 1 00 00003738
3 1 0 00 00000039
3 0 2 00 000029B1
3 1 2 10 00000000
3 1 2 14 00000007
3 1 2 08 00000011
3 1 2 00 31323334
3 1 2 00 35363738
3 1 0 00 00000039
3 0 2 00 000000F4
3 1 2 14 00000009
3 1 2 08 00000019
3 1 2 00 31323334
3 1 2 00 35363738
3 1 0 00 00000039
3 0 2 00 00000075
// Reflected CRC-32 without final xor, byte and word input reversal
4 1 2 10 FFFFFFFF
4 1 2 14 04C11DB7
4 1 2 08 000000A1
4 0 2 08 000000A0
4 1 2 00 31323334
4 1 2 00 35363738
4 1 0 00 00000039
4 0 2 00 340BC6D9
4 1 2 08 000000E1
4 0 2 08 000000E0
4 1 2 00 34333231
4 1 2 00 38373635
4 1 0 00 00000039
4 0 2 00 340BC6D9
// Back-to-back halfwords, DR read right behind them
5 1 2 08 00000001
5 0 2 08 00000000
5 1 1 00 00003132
5 1 1 00 00003334
5 1 1 00 00003536
5 1 1 00 00003738
5 1 0 00 00000039
5 0 2 00 0376E6E7
// IDR width and CR read back
6 1 2 04 123456A5
6 0 2 04 000000A5
6 1 2 08 00000099
6 0 2 08 00000098
0 0 0 00 00000000
